// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_issue_scoreboard
FILELIST = project.f

BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "Testbench passed" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/issue_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter
    import scoreboard_pkg::*;
#(
    // Multiplier pipeline depth
    parameter int unsigned MUL_LATENCY = 5,
    // Divider cycles per operation
    parameter int unsigned DIV_LATENCY = 36
) (
    // Dispatched instruction
    input  wire issue_req_t      req_i,

    // Status from the unit trackers
    input  wire tracker_status_t mul_status_i,
    input  wire tracker_status_t div_status_i,

    // Latency of the dispatched instruction, back to the trackers
    output latency_t             req_latency_o,

    output logic                 issue_o,
    output logic                 pipeline_empty_o
);

    // ======================================================================
    // Latency decode
    // ======================================================================

    // Bypass stage already included by the lookup
    assign req_latency_o = unit_latency(req_i.unit, MUL_LATENCY, DIV_LATENCY);

    // ======================================================================
    // Hazard merge
    // ======================================================================

    logic raw_hazard;
    logic wb_hazard;
    logic busy_hazard;

    // Operand or destination still pending in either unit
    assign raw_hazard  = mul_status_i.raw_hazard  || div_status_i.raw_hazard;

    // Two results on the write-back port in the same cycle
    assign wb_hazard   = mul_status_i.wb_hazard   || div_status_i.wb_hazard;

    // Needed slot still occupied
    assign busy_hazard = mul_status_i.busy_hazard || div_status_i.busy_hazard;

    // ======================================================================
    // Outputs
    // ======================================================================

    // Any hazard holds the instruction in dispatch
    assign issue_o = !(raw_hazard || wb_hazard || busy_hazard);

    // Nothing left in flight in either unit
    assign pipeline_empty_o = !(mul_status_i.executing || div_status_i.executing);

endmodule : issue_arbiter

`default_nettype wire

// File: hw/issue_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module issue_scoreboard
    import scoreboard_pkg::*;
#(
    parameter int unsigned MUL_LATENCY = 5,
    parameter int unsigned DIV_LATENCY = 36
) (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       flush_i,
    input  wire logic       stall_i,

    // Instruction waiting in dispatch
    input  wire issue_req_t req_i,

    output logic            issue_o,
    output logic            pipeline_empty_o
);

    // ======================================================================
    // Internal connections
    // ======================================================================

    latency_t        req_latency;
    tracker_status_t mul_status;
    tracker_status_t div_status;

    // ======================================================================
    // Unit trackers
    // ======================================================================

    // Fully pipelined multiplier, one slot per stage
    unit_tracker #(
        .STAGES  (MUL_LATENCY),
        .LATENCY (MUL_LATENCY)
    ) mul_tracker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .req_i         (req_i),
        .start_i       (req_i.unit.mul),
        .issue_i       (issue_o),
        .req_latency_i (req_latency),
        .status_o      (mul_status)
    );

    // Iterative divider, single operation at a time
    unit_tracker #(
        .STAGES  (1),
        .LATENCY (DIV_LATENCY)
    ) div_tracker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .req_i         (req_i),
        .start_i       (req_i.unit.div),
        .issue_i       (issue_o),
        .req_latency_i (req_latency),
        .status_o      (div_status)
    );

    // ======================================================================
    // Issue decision
    // ======================================================================

    issue_arbiter #(
        .MUL_LATENCY (MUL_LATENCY),
        .DIV_LATENCY (DIV_LATENCY)
    ) arbiter (
        .req_i            (req_i),
        .mul_status_i     (mul_status),
        .div_status_i     (div_status),
        .req_latency_o    (req_latency),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

endmodule : issue_scoreboard

`default_nettype wire

// File: hw/scoreboard_pkg.sv
`default_nettype none

package scoreboard_pkg;

    // ======================================================================
    // Basic types
    // ======================================================================

    // Architectural register address, x0 is hardwired to zero
    typedef logic [4:0] reg_addr_t;

    // Remaining cycles of a slot or requested latency of a request
    // All ones means that no unit is selected
    typedef logic [5:0] latency_t;

    // One-hot unit select, at most one field set
    typedef struct packed {
        logic alu;
        logic csr;
        logic mul;
        logic div;
    } unit_sel_t;

    // Dispatched instruction as seen by the scoreboard
    typedef struct packed {
        reg_addr_t src_a;
        reg_addr_t src_b;
        reg_addr_t dest;
        unit_sel_t unit;
    } issue_req_t;

    // Per-unit hazard summary
    typedef struct packed {
        logic raw_hazard;
        logic wb_hazard;
        logic busy_hazard;
        logic executing;
    } tracker_status_t;

    // ======================================================================
    // Latencies
    // ======================================================================

    // Extra cycle for the bypass stage in front of execution
    localparam int unsigned BYPASS_CYCLES = 1;

    // ALU and CSR produce their result in one cycle
    localparam int unsigned COMB_LATENCY = 1;

    // Requested latency of a dispatched unit
    function automatic latency_t unit_latency(
        input unit_sel_t   unit,
        input int unsigned mul_latency,
        input int unsigned div_latency
    );
        if (unit.mul) begin
            return latency_t'(mul_latency + BYPASS_CYCLES);
        end else if (unit.div) begin
            return latency_t'(div_latency + BYPASS_CYCLES);
        end else if (unit.alu || unit.csr) begin
            return latency_t'(COMB_LATENCY + BYPASS_CYCLES);
        end
        // Nothing selected, never equal to a live count
        return '1;
    endfunction

endpackage : scoreboard_pkg

`default_nettype wire

// File: hw/unit_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module unit_tracker
    import scoreboard_pkg::*;
#(
    // Number of operations that may be in flight at once
    parameter int unsigned STAGES  = 1,
    // Cycles loaded into a slot when its operation issues
    parameter int unsigned LATENCY = 1
) (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            flush_i,
    input  wire logic            stall_i,

    // Dispatched instruction
    input  wire issue_req_t      req_i,
    // Instruction targets this unit
    input  wire logic            start_i,
    // Instruction leaves dispatch this cycle
    input  wire logic            issue_i,
    // Latency that the dispatched instruction would take
    input  wire latency_t        req_latency_i,

    output tracker_status_t      status_o
);

    // ======================================================================
    // Slot selection
    // ======================================================================

    // Slot is loaded on an unstalled edge that issues to this unit
    logic load_en;

    assign load_en = !stall_i && start_i && issue_i;

    // One-hot pointer to the next slot to fill
    logic [STAGES-1:0] slot_ptr;

    always_ff @(posedge clk_i) begin : slot_pointer
        if (!rst_n_i) begin
            slot_ptr <= STAGES'(1);
        end else if (flush_i) begin
            slot_ptr <= STAGES'(1);
        end else if (load_en) begin
            if (slot_ptr[STAGES-1]) begin
                // Last slot used, go back to slot 0
                slot_ptr <= STAGES'(1);
            end else begin
                slot_ptr <= slot_ptr << 1;
            end
        end
    end : slot_pointer

    // ======================================================================
    // Slot state
    // ======================================================================

    latency_t  [STAGES-1:0] slot_cnt;
    reg_addr_t [STAGES-1:0] slot_dest;

    // Per-slot hazard flags
    logic [STAGES-1:0] slot_executing;
    logic [STAGES-1:0] slot_raw;
    logic [STAGES-1:0] slot_wb;

    for (genvar i = 0; i < STAGES; i++) begin : g_slot

        // Remaining cycles until the result is written back
        always_ff @(posedge clk_i) begin : slot_counter
            if (!rst_n_i) begin
                slot_cnt[i] <= '0;
            end else if (flush_i) begin
                // Operations in flight are dropped
                slot_cnt[i] <= '0;
            end else if (!stall_i) begin
                if (load_en && slot_ptr[i]) begin
                    slot_cnt[i] <= latency_t'(LATENCY);
                end else if (slot_cnt[i] != '0) begin
                    slot_cnt[i] <= slot_cnt[i] - latency_t'(1);
                end
            end
        end : slot_counter

        // Destination of the operation held by this slot
        always_ff @(posedge clk_i) begin : slot_destination
            if (load_en && slot_ptr[i]) begin
                slot_dest[i] <= req_i.dest;
            end
        end : slot_destination

        // Last cycle of a slot already frees its result through the bypass
        assign slot_executing[i] = (slot_cnt[i] > latency_t'(1));

        // Any operand or the destination hits a pending write
        // x0 is never written, so it never matches
        assign slot_raw[i] = slot_executing[i]
                           && (slot_dest[i] != '0)
                           && ((req_i.src_a == slot_dest[i])
                            || (req_i.src_b == slot_dest[i])
                            || (req_i.dest  == slot_dest[i]));

        // New instruction would write back together with this slot
        assign slot_wb[i] = slot_executing[i] && (slot_cnt[i] == req_latency_i);

    end : g_slot

    // ======================================================================
    // Status
    // ======================================================================

    // Slot that a new operation would take
    logic ptr_slot_busy;

    assign ptr_slot_busy = |(slot_ptr & slot_executing);

    assign status_o.raw_hazard  = |slot_raw;
    assign status_o.wb_hazard   = |slot_wb;
    // Only a request for this unit can collide on a slot
    assign status_o.busy_hazard = start_i && ptr_slot_busy;
    assign status_o.executing   = |slot_executing;

endmodule : unit_tracker

`default_nettype wire

// File: project.f
+incdir+testbench
hw/scoreboard_pkg.sv
hw/unit_tracker.sv
hw/issue_arbiter.sv
hw/issue_scoreboard.sv
testbench/scoreboard_assert.sv
testbench/tb_issue_scoreboard.sv

// File: testbench/scoreboard_assert.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_assert
    import scoreboard_pkg::*;
(
    input wire logic       clk_i,
    input wire logic       rst_n_i,
    input wire logic       flush_i,
    input wire issue_req_t req_i,
    input wire logic       issue_i,
    input wire logic       pipeline_empty_i
);

    // Number of failed assertions
    int unsigned failure_count = 0;

    // ======================================================================
    // Protocol checks
    // ======================================================================

    // Flush drops every operation in flight
    flush_empties: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> pipeline_empty_i)
        else begin
            failure_count++;
            $error("pipeline not empty one cycle after flush");
        end

    // No slot executing means no hazard source
    empty_issues: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pipeline_empty_i |-> issue_i)
        else begin
            failure_count++;
            $error("issue low while pipeline empty");
        end

    // Dispatch selects at most one unit
    unit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(req_i.unit))
        else begin
            failure_count++;
            $error("request selects more than one unit");
        end

endmodule : scoreboard_assert

bind issue_scoreboard scoreboard_assert scoreboard_assert_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .req_i            (req_i),
    .issue_i          (issue_o),
    .pipeline_empty_i (pipeline_empty_o)
);

`default_nettype wire

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH
`default_nettype none

// Per-cycle stimulus and expected outputs, one row held for "cycles" clocks
// Columns: cycles, flush, stall, src_a, src_b, dest, unit, issue, empty
// Requested latency is unit latency plus bypass: ALU/CSR 2, MUL 6, DIV 37
function automatic void load_vectors();
    // Reset state, nothing in flight
    add_row( 1, 0, 0,  1,  2,  3, U_ALU,  1, 1);
    add_row( 1, 0, 0,  1,  2,  3, U_CSR,  1, 1);
    // MUL to r5, readers of r5 wait while the slot count is above 1
    add_row( 1, 0, 0,  1,  2,  5, U_MUL,  1, 1);
    add_row( 4, 0, 0,  5,  1,  6, U_ALU,  0, 0);
    add_row( 1, 0, 0,  5,  1,  6, U_ALU,  1, 1);
    // MUL to r0, x0 never matches
    add_row( 1, 0, 0,  0,  0,  0, U_MUL,  1, 1);
    add_row( 3, 0, 0,  0,  0,  0, U_ALU,  1, 0);
    // Count 2 here, idle request avoids the write-back slot
    add_row( 1, 0, 0,  0,  0,  0, U_NONE, 1, 0);
    add_row( 1, 0, 0,  0,  0,  0, U_NONE, 1, 1);
    // Five back-to-back MULs fill every slot of the pipeline
    add_row( 1, 0, 0, 10, 11, 20, U_MUL,  1, 1);
    add_row( 1, 0, 0, 10, 11, 21, U_MUL,  1, 0);
    add_row( 1, 0, 0, 10, 11, 22, U_MUL,  1, 0);
    add_row( 1, 0, 0, 10, 11, 23, U_MUL,  1, 0);
    add_row( 1, 0, 0, 10, 11, 24, U_MUL,  1, 0);
    // Drain, last MUL counts 5 down to 2
    add_row( 4, 0, 0,  0,  0,  0, U_NONE, 1, 0);
    add_row( 1, 0, 0,  0,  0,  0, U_NONE, 1, 1);
    // ALU with latency 2 collides when the MUL slot reaches 2
    add_row( 1, 0, 0,  1,  2,  7, U_MUL,  1, 1);
    add_row( 3, 0, 0,  8,  9, 10, U_ALU,  1, 0);
    add_row( 1, 0, 0,  8,  9, 10, U_ALU,  0, 0);
    add_row( 1, 0, 0,  8,  9, 10, U_ALU,  1, 1);
    // DIV holds its single slot for 35 cycles
    add_row( 1, 0, 0,  1,  2, 12, U_DIV,  1, 1);
    add_row(35, 0, 0,  3,  4, 13, U_DIV,  0, 0);
    add_row( 1, 0, 0,  3,  4, 13, U_DIV,  1, 1);
    // Same window with a 5-cycle stall in the middle, 40 cycles blocked
    add_row(10, 0, 0,  3,  4, 14, U_DIV,  0, 0);
    add_row( 5, 0, 1,  3,  4, 14, U_DIV,  0, 0);
    add_row(25, 0, 0,  3,  4, 14, U_DIV,  0, 0);
    add_row( 1, 0, 0,  3,  4, 14, U_DIV,  1, 1);
    // Flush drops the DIV in flight
    add_row( 3, 0, 0,  0,  0,  0, U_NONE, 1, 0);
    add_row( 1, 0, 0,  3,  4, 15, U_DIV,  0, 0);
    add_row( 1, 1, 0,  3,  4, 15, U_DIV,  0, 0);
    add_row( 1, 0, 0,  3,  4, 15, U_DIV,  1, 1);
    add_row( 1, 0, 0,  0,  0,  0, U_NONE, 1, 0);
    add_row( 1, 1, 0,  0,  0,  0, U_NONE, 1, 0);
    add_row( 1, 0, 0,  0,  0,  0, U_NONE, 1, 1);
endfunction

`default_nettype wire
`endif

// File: testbench/tb_issue_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_scoreboard
    import scoreboard_pkg::*;
();

    // ======================================================================
    // Parameters and types
    // ======================================================================

    localparam int unsigned MUL_LATENCY   = 5;
    localparam int unsigned DIV_LATENCY   = 36;
    localparam int unsigned CLK_PERIOD    = 4;
    localparam int unsigned RESET_CYCLES  = 16;
    // Slack on top of reset and table length
    localparam int unsigned MARGIN_CYCLES = 20;

    // Unit select constants in alu, csr, mul, div field order
    localparam unit_sel_t U_NONE = 4'b0000;
    localparam unit_sel_t U_ALU  = 4'b1000;
    localparam unit_sel_t U_CSR  = 4'b0100;
    localparam unit_sel_t U_MUL  = 4'b0010;
    localparam unit_sel_t U_DIV  = 4'b0001;

    // One table row held for a number of cycles
    typedef struct packed {
        int unsigned cycles;
        logic        flush;
        logic        stall;
        issue_req_t  req;
        logic        exp_issue;
        logic        exp_empty;
    } vector_t;

    // ======================================================================
    // DUT and clock
    // ======================================================================

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    logic       flush_i;
    logic       stall_i;
    issue_req_t req_i;
    logic       issue_o;
    logic       pipeline_empty_o;

    vector_t     vectors[$];
    int unsigned total_cycles  = 0;
    int unsigned check_count   = 0;
    int unsigned issue_errors  = 0;
    int unsigned empty_errors  = 0;
    int unsigned assert_errors = 0;
    logic        table_ready   = 1'b0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    issue_scoreboard #(
        .MUL_LATENCY (MUL_LATENCY),
        .DIV_LATENCY (DIV_LATENCY)
    ) issue_scoreboard_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .req_i            (req_i),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

    // ======================================================================
    // Table and compare tasks
    // ======================================================================

    function automatic void add_row(
        input int unsigned cycles,
        input int unsigned flush,
        input int unsigned stall,
        input int unsigned src_a,
        input int unsigned src_b,
        input int unsigned dest,
        input unit_sel_t   unit,
        input int unsigned exp_issue,
        input int unsigned exp_empty
    );
        vector_t row;
        row.cycles    = cycles;
        row.flush     = (flush != 0);
        row.stall     = (stall != 0);
        row.req.src_a = reg_addr_t'(src_a);
        row.req.src_b = reg_addr_t'(src_b);
        row.req.dest  = reg_addr_t'(dest);
        row.req.unit  = unit;
        row.exp_issue = (exp_issue != 0);
        row.exp_empty = (exp_empty != 0);
        vectors.push_back(row);
        total_cycles += cycles;
    endfunction

    `include "tb_vectors.svh"

    task automatic check_issue(input logic actual, input logic expected, input int row_idx);
        check_count++;
        if (actual !== expected) begin
            issue_errors++;
            $display("Mismatch at %0t: issue_o = %b, expected %b (row %0d)",
                     $time, actual, expected, row_idx);
        end
    endtask

    task automatic check_empty(input logic actual, input logic expected, input int row_idx);
        check_count++;
        if (actual !== expected) begin
            empty_errors++;
            $display("Mismatch at %0t: pipeline_empty_o = %b, expected %b (row %0d)",
                     $time, actual, expected, row_idx);
        end
    endtask

    // ======================================================================
    // Stimulus and verdict
    // ======================================================================

    initial begin : stimulus
        vector_t row;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        stall_i = 1'b0;
        req_i   = '0;
        load_vectors();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        foreach (vectors[i]) begin
            row = vectors[i];
            repeat (row.cycles) begin
                @(posedge clk_i);
                flush_i <= row.flush;
                stall_i <= row.stall;
                req_i   <= row.req;
                // Outputs settled by mid cycle
                @(negedge clk_i);
                check_issue(issue_o, row.exp_issue, i);
                check_empty(pipeline_empty_o, row.exp_empty, i);
            end
        end
        @(posedge clk_i);
        flush_i <= 1'b0;
        stall_i <= 1'b0;
        req_i   <= '0;
        // Failures of the bound checker
        assert_errors = issue_scoreboard_inst.scoreboard_assert_inst.failure_count;
        $display("Checks: %0d, issue errors: %0d, empty errors: %0d, assertion errors: %0d",
                 check_count, issue_errors, empty_errors, assert_errors);
        if (issue_errors == 0 && empty_errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end : stimulus

    // Run length follows the table size
    initial begin : watchdog
        wait (table_ready);
        #((total_cycles + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not reach the end of the vector table");
        $display("Testbench failed");
        $finish;
    end : watchdog

endmodule : tb_issue_scoreboard

`default_nettype wire
